// File: common/uart_bridge_pkg.sv
`default_nettype none

package uart_bridge_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    // UART-Lite is a 32-bit register device
    localparam int axi_addr_width = 32;
    localparam int axi_data_width = 32;
    // One strobe per data byte
    localparam int axi_strb_width = axi_data_width / 8;

    // ----------------------------------------
    // UART-Lite register map
    // ----------------------------------------
    // Offsets from the UART base address
    localparam int uart_tx_offset   = 4;
    localparam int uart_ctrl_offset = 12;

    // Basic data types
    typedef logic [7:0]                byte_t;
    typedef logic [axi_addr_width-1:0] axi_addr_t;
    typedef logic [axi_data_width-1:0] axi_data_t;

    // Control register value with the interrupt enable bit (bit 4) set
    localparam axi_data_t uart_ctrl_intr_enable = 32'h0000_0010;

    // AXI write response codes
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // One register write, address and data
    typedef struct packed {
        axi_addr_t addr;
        axi_data_t data;
    } wr_cmd_t;

    // Sequencer FSM
    typedef enum logic [1:0] {init, wait_char, wait_done} tx_state_e;

    // Write master FSM
    typedef enum logic [1:0] {idle, addr_data, resp} wr_state_e;

endpackage

`default_nettype wire

// File: hw/xmit_fifo.sv
`default_nettype none

module xmit_fifo #(
    // Must be a power of two, at least 2
    parameter int XMIT_DEPTH = 1024
) (
    input  wire                            M_AXI_ACLK,
    input  wire                            M_AXI_ARESETN,
    // Write side, user facing
    input  wire uart_bridge_pkg::byte_t    din,
    input  wire                            wren,
    output logic                           full_n,
    // Read side, first-word-fall-through
    output uart_bridge_pkg::byte_t         head,
    output logic                           empty,
    input  wire                            pop
);

    import uart_bridge_pkg::*;

    // Index width and pointer width with one extra wrap bit
    localparam int idx_w = $clog2(XMIT_DEPTH);

    // Storage array
    byte_t mem [XMIT_DEPTH];

    // Pointers carry a wrap bit to tell full from empty
    logic [idx_w:0] wr_ptr;
    logic [idx_w:0] rd_ptr;

    // Accepted push and accepted pop this cycle
    logic push_ok;
    logic pop_ok;

    // ----------------------------------------
    // Status flags
    // ----------------------------------------
    // Same index, same wrap bit means nothing stored
    assign empty  = (wr_ptr == rd_ptr);
    // Same index, different wrap bit means every slot in use
    assign full_n = !((wr_ptr[idx_w] != rd_ptr[idx_w]) &&
                      (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]));

    // A write while full is dropped
    assign push_ok = wren && full_n;
    // Popping an empty FIFO does nothing
    assign pop_ok  = pop && !empty;

    // Head comes straight out of the array
    assign head = mem[rd_ptr[idx_w-1:0]];

    // ----------------------------------------
    // Storage write
    // ----------------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (push_ok) begin
            mem[wr_ptr[idx_w-1:0]] <= din;
        end
    end

    // ----------------------------------------
    // Pointer update
    // ----------------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Push and pop may land in the same cycle
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx_sequencer.sv
`default_nettype none

module uart_tx_sequencer #(
    // UART-Lite base address
    parameter uart_bridge_pkg::axi_addr_t UART_ADDR = 32'h4060_0000
) (
    input  wire                             M_AXI_ACLK,
    input  wire                             M_AXI_ARESETN,
    // From the transmit FIFO
    input  wire uart_bridge_pkg::byte_t     head,
    input  wire                             empty,
    output logic                            pop,
    // To the write master
    output uart_bridge_pkg::wr_cmd_t        cmd,
    output logic                            write,
    input  wire                             idle,
    input  wire uart_bridge_pkg::axi_resp_e resp
);

    import uart_bridge_pkg::*;

    // Register addresses inside the UART-Lite
    localparam axi_addr_t tx_addr   = UART_ADDR + axi_addr_t'(uart_tx_offset);
    localparam axi_addr_t ctrl_addr = UART_ADDR + axi_addr_t'(uart_ctrl_offset);

    tx_state_e state;

    // ----------------------------------------
    // Sequencer FSM
    // ----------------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        // write and pop are single-cycle pulses
        write <= 1'b0;
        pop   <= 1'b0;

        if (!M_AXI_ARESETN) begin
            state <= init;
            write <= 1'b0;
            pop   <= 1'b0;
        end else begin
            case (state)
                // Turn on UART interrupts once after reset
                init: begin
                    cmd.addr <= ctrl_addr;
                    cmd.data <= uart_ctrl_intr_enable;
                    write    <= 1'b1;
                    // Response is not checked here, never retried
                    state    <= wait_char;
                end

                // Wait for the bus to go quiet and a byte to show up
                wait_char: begin
                    if (idle && !empty) begin
                        cmd.addr <= tx_addr;
                        // Byte goes out zero-extended
                        cmd.data <= axi_data_t'(head);
                        write    <= 1'b1;
                        // Byte leaves the FIFO with its write pulse
                        pop      <= 1'b1;
                        state    <= wait_done;
                    end
                end

                // Wait for the transmit write to finish
                wait_done: begin
                    if (idle) begin
                        if (resp == okay) begin
                            state <= wait_char;
                        end else begin
                            // Slave refused, send the held command again
                            write <= 1'b1;
                        end
                    end
                end

                default: begin
                    state <= init;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: axi_write/axi_write_master.sv
`default_nettype none

module axi_write_master (
    input  wire                                         M_AXI_ACLK,
    input  wire                                         M_AXI_ARESETN,
    // Command side
    input  wire uart_bridge_pkg::wr_cmd_t               cmd,
    input  wire                                         write,
    output logic                                        idle,
    output uart_bridge_pkg::axi_resp_e                  resp,
    // AW channel
    output uart_bridge_pkg::axi_addr_t                  m_axi_awaddr,
    output logic                                        m_axi_awvalid,
    output logic [2:0]                                  m_axi_awprot,
    input  wire                                         m_axi_awready,
    // W channel
    output uart_bridge_pkg::axi_data_t                  m_axi_wdata,
    output logic                                        m_axi_wvalid,
    output logic [uart_bridge_pkg::axi_strb_width-1:0]  m_axi_wstrb,
    input  wire                                         m_axi_wready,
    // B channel
    input  wire uart_bridge_pkg::axi_resp_e             m_axi_bresp,
    input  wire                                         m_axi_bvalid,
    output logic                                        m_axi_bready
);

    import uart_bridge_pkg::*;

    // State literals idle and resp are shadowed by the ports of the same name,
    // so they are written with the package scope below
    wr_state_e state;

    // Latched command for the transfer in flight
    wr_cmd_t cmd_q;

    // Handshakes already seen on AW and W
    logic saw_aw;
    logic saw_w;

    // Handshakes in this cycle
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign aw_hs = m_axi_awvalid && m_axi_awready;
    assign w_hs  = m_axi_wvalid && m_axi_wready;
    assign b_hs  = m_axi_bvalid && m_axi_bready;

    // ----------------------------------------
    // Fixed and latched bus outputs
    // ----------------------------------------
    // Unprivileged, secure, data access
    assign m_axi_awprot = 3'b000;
    // Full-word writes only
    assign m_axi_wstrb  = '1;
    assign m_axi_awaddr = cmd_q.addr;
    assign m_axi_wdata  = cmd_q.data;

    // Busy as soon as a write pulse shows up
    assign idle = (state == uart_bridge_pkg::idle) && !write;

    // ----------------------------------------
    // Write FSM
    // ----------------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state         <= uart_bridge_pkg::idle;
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
            m_axi_bready  <= 1'b0;
            saw_aw        <= 1'b0;
            saw_w         <= 1'b0;
        end else begin
            case (state)
                // Take the command and raise both valids plus bready
                uart_bridge_pkg::idle: begin
                    if (write) begin
                        cmd_q         <= cmd;
                        saw_aw        <= 1'b0;
                        saw_w         <= 1'b0;
                        m_axi_awvalid <= 1'b1;
                        m_axi_wvalid  <= 1'b1;
                        m_axi_bready  <= 1'b1;
                        state         <= addr_data;
                    end
                end

                // AW and W may complete in either order or together
                addr_data: begin
                    if (aw_hs) begin
                        saw_aw        <= 1'b1;
                        m_axi_awvalid <= 1'b0;
                    end
                    if (w_hs) begin
                        saw_w        <= 1'b1;
                        m_axi_wvalid <= 1'b0;
                    end
                    if ((saw_aw || aw_hs) && (saw_w || w_hs)) begin
                        state <= uart_bridge_pkg::resp;
                    end
                end

                // Hold bready until the slave answers
                uart_bridge_pkg::resp: begin
                    if (b_hs) begin
                        resp         <= m_axi_bresp;
                        m_axi_bready <= 1'b0;
                        state        <= uart_bridge_pkg::idle;
                    end
                end

                default: begin
                    state <= uart_bridge_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/fifo_to_uart_tx.sv
`default_nettype none

module fifo_to_uart_tx #(
    parameter int                         XMIT_DEPTH = 1024,
    parameter uart_bridge_pkg::axi_addr_t UART_ADDR  = 32'h4060_0000
) (
    input  wire                                         M_AXI_ACLK,
    input  wire                                         M_AXI_ARESETN,
    // User byte port
    input  wire uart_bridge_pkg::byte_t                 xmit_data,
    input  wire                                         xmit_wren,
    output logic                                        xmit_full_n,
    // AXI4-Lite write channels
    output uart_bridge_pkg::axi_addr_t                  m_axi_awaddr,
    output logic                                        m_axi_awvalid,
    output logic [2:0]                                  m_axi_awprot,
    input  wire                                         m_axi_awready,
    output uart_bridge_pkg::axi_data_t                  m_axi_wdata,
    output logic                                        m_axi_wvalid,
    output logic [uart_bridge_pkg::axi_strb_width-1:0]  m_axi_wstrb,
    input  wire                                         m_axi_wready,
    input  wire uart_bridge_pkg::axi_resp_e             m_axi_bresp,
    input  wire                                         m_axi_bvalid,
    output logic                                        m_axi_bready
);

    import uart_bridge_pkg::*;

    // FIFO to sequencer
    byte_t     fifo_head;
    logic      fifo_empty;
    logic      fifo_pop;

    // Sequencer to write master
    wr_cmd_t   wr_cmd;
    logic      wr_pulse;
    logic      wr_idle;
    axi_resp_e wr_resp;

    // ----------------------------------------
    // Byte buffer
    // ----------------------------------------
    xmit_fifo #(
        .XMIT_DEPTH (XMIT_DEPTH)
    ) u_xmit_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .din           (xmit_data),
        .wren          (xmit_wren),
        .full_n        (xmit_full_n),
        .head          (fifo_head),
        .empty         (fifo_empty),
        .pop           (fifo_pop)
    );

    // UART register sequencing
    uart_tx_sequencer #(
        .UART_ADDR (UART_ADDR)
    ) u_uart_tx_sequencer (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .head          (fifo_head),
        .empty         (fifo_empty),
        .pop           (fifo_pop),
        .cmd           (wr_cmd),
        .write         (wr_pulse),
        .idle          (wr_idle),
        .resp          (wr_resp)
    );

    // AXI4-Lite write engine
    axi_write_master u_axi_write_master (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .cmd           (wr_cmd),
        .write         (wr_pulse),
        .idle          (wr_idle),
        .resp          (wr_resp),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awprot  (m_axi_awprot),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

endmodule

`default_nettype wire

// File: test/fifo_to_uart_tx_sva.sv
`default_nettype none

module fifo_to_uart_tx_sva (
    input wire                             M_AXI_ACLK,
    input wire                             M_AXI_ARESETN,
    input wire                             m_axi_awvalid,
    input wire                             m_axi_awready,
    input wire uart_bridge_pkg::axi_addr_t m_axi_awaddr,
    input wire                             m_axi_wvalid,
    input wire                             m_axi_wready,
    input wire uart_bridge_pkg::axi_data_t m_axi_wdata,
    input wire                             m_axi_bvalid,
    input wire                             m_axi_bready,
    // Sequencer side of the master
    input wire                             write,
    input wire                             idle
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // AXI write handshake rules
    // ----------------------------------------
    // AW held with a stable address until accepted
    aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    // Same for W and its data
    w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
        else $error("wvalid dropped or wdata moved before wready");

    b_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_bready && !m_axi_bvalid |=> m_axi_bready)
        else $error("bready dropped before bvalid");

    // Quiet bus right after a reset edge
    reset_quiet: assert property (@(posedge M_AXI_ACLK)
        !M_AXI_ARESETN |=> !m_axi_awvalid && !m_axi_wvalid && !m_axi_bready)
        else $error("AXI valid or bready high after reset");

    // idle includes the pulse itself, so look one edge back
    write_when_idle: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        write |-> $past(idle))
        else $error("write pulse while the master was busy");

endmodule

`default_nettype wire

// File: test/tb_fifo_to_uart_tx.sv
`default_nettype none

module tb_fifo_to_uart_tx;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_bridge_pkg::*;

    // ----------------------------------------
    // Test setup
    // ----------------------------------------
    localparam int        XMIT_DEPTH  = 8;
    localparam axi_addr_t UART_ADDR   = 32'h4060_0000;
    localparam int        RAND_BYTES  = 24;
    localparam int        HOLD_PUSHES = 14;
    localparam int        HOLD_CYCLES = 30;
    // Ready and bvalid delays run from 0 to this many cycles
    localparam int        MAX_STALL   = 3;
    // Refusals in a row before the slave answers okay
    localparam int        MAX_RETRY   = 2;
    localparam int        PUSH_CYCLES = RAND_BYTES * 12 + HOLD_PUSHES + HOLD_CYCLES;
    // Worst case per write times writes per byte, plus push time
    localparam int        WATCHDOG_CYCLES = (RAND_BYTES + HOLD_PUSHES + 1) *
                                            (MAX_RETRY + 1) * (2 * MAX_STALL + 10) +
                                            PUSH_CYCLES + 100;

    // Clock starts low without an edge at time zero
    logic                      M_AXI_ACLK = 1'b0;
    logic                      M_AXI_ARESETN;
    byte_t                     xmit_data;
    logic                      xmit_wren;
    logic                      xmit_full_n;
    axi_addr_t                 m_axi_awaddr;
    logic                      m_axi_awvalid;
    logic [2:0]                m_axi_awprot;
    logic                      m_axi_awready;
    axi_data_t                 m_axi_wdata;
    logic                      m_axi_wvalid;
    logic [axi_strb_width-1:0] m_axi_wstrb;
    logic                      m_axi_wready;
    axi_resp_e                 m_axi_bresp;
    logic                      m_axi_bvalid;
    logic                      m_axi_bready;

    // Scoreboard
    byte_t     accepted [$];
    wr_cmd_t   wr_log   [$];
    axi_resp_e resp_log [$];
    int        okay_tx;
    int        checked;
    int        dropped;

    // Slave model state
    logic [31:0] stim_seed;
    logic [31:0] slave_seed;
    logic        hold_aw;
    logic        got_aw;
    logic        got_w;
    int          aw_wait;
    int          w_wait;
    int          b_wait;
    int          retry_run;
    wr_cmd_t     cur;

    fifo_to_uart_tx #(
        .XMIT_DEPTH (XMIT_DEPTH),
        .UART_ADDR  (UART_ADDR)
    ) u_fifo_to_uart_tx (.*);

    bind axi_write_master fifo_to_uart_tx_sva u_write_sva (.*);

    initial begin : clock_gen
        forever #5 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int stall_from(input logic [31:0] s);
        return int'(s[20:16]) % (MAX_STALL + 1);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // Expected write number idx, 0 if it runs past the accepted bytes
    function automatic bit ref_write(input int idx, output wr_cmd_t want);
        int k;
        int b;
        b = 0;
        want.addr = UART_ADDR + 32'd12;
        want.data = 32'h0000_0010;
        if (idx == 0) begin
            return 1'b1;
        end
        // Each okay before this write moved on to the next byte
        for (k = 1; k < idx; k++) begin
            if (resp_log[k] == okay) begin
                b++;
            end
        end
        if (b >= accepted.size()) begin
            return 1'b0;
        end
        want.addr = UART_ADDR + 32'd4;
        want.data = {24'h0, accepted[b]};
        return 1'b1;
    endfunction

    task automatic check_write(input wr_cmd_t actual, input wr_cmd_t want, input int idx);
        if (actual !== want) begin
            abort_run($sformatf("mismatch at %0t: write %0d addr %h data %h, expected %h %h",
                                $time, idx, actual.addr, actual.data, want.addr, want.data));
        end
    endtask

    task automatic check_full(input logic actual, input logic want, input string what);
        if (actual !== want) begin
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                                $time, what, actual, want));
        end
    endtask

    task automatic check_attrs(input logic [2:0] prot, input logic [axi_strb_width-1:0] strb);
        if (prot !== 3'b000 || strb !== '1) begin
            abort_run($sformatf("mismatch at %0t: awprot %b wstrb %b, expected 000 and all ones",
                                $time, prot, strb));
        end
    endtask

    task automatic reload_delays();
        slave_seed = lcg_step(slave_seed);
        aw_wait    = stall_from(slave_seed);
        slave_seed = lcg_step(slave_seed);
        w_wait     = stall_from(slave_seed);
        slave_seed = lcg_step(slave_seed);
        b_wait     = stall_from(slave_seed);
    endtask

    // Called just after a falling edge, the byte counts if full_n is high now
    task automatic push_byte(input byte_t value);
        xmit_data = value;
        xmit_wren = 1'b1;
        if (xmit_full_n) begin
            accepted.push_back(value);
        end else begin
            dropped++;
        end
        @(negedge M_AXI_ACLK);
        xmit_wren = 1'b0;
    endtask

    task automatic wait_drained();
        while (okay_tx < accepted.size()) begin
            @(posedge M_AXI_ACLK);
        end
        @(negedge M_AXI_ACLK);
    endtask

    // ----------------------------------------
    // AXI slave model
    // ----------------------------------------
    always @(negedge M_AXI_ACLK) begin
        // B first, it only sees AW and W handshakes of earlier edges
        if (m_axi_bvalid) begin
            // B handshake took place on the last rising edge
            m_axi_bvalid = 1'b0;
            got_aw       = 1'b0;
            got_w        = 1'b0;
            reload_delays();
        end else if (got_aw && got_w) begin
            if (b_wait > 0) begin
                b_wait--;
            end else if (m_axi_bready) begin
                slave_seed = lcg_step(slave_seed);
                if (wr_log.size() == 0) begin
                    // Control write refused, must not come back
                    m_axi_bresp = slverr;
                end else if (retry_run >= MAX_RETRY || slave_seed[17:16] > 2'd1) begin
                    m_axi_bresp = okay;
                    retry_run   = 0;
                end else begin
                    m_axi_bresp = slave_seed[16] ? decerr : slverr;
                    retry_run++;
                end
                m_axi_bvalid = 1'b1;
                wr_log.push_back(cur);
                resp_log.push_back(m_axi_bresp);
                if (resp_log.size() > 1 && m_axi_bresp == okay) begin
                    okay_tx++;
                end
            end
        end

        // AW channel, frozen while held
        m_axi_awready = 1'b0;
        if (m_axi_awvalid && !got_aw && !hold_aw) begin
            if (aw_wait > 0) begin
                aw_wait--;
            end else begin
                m_axi_awready = 1'b1;
                got_aw        = 1'b1;
                cur.addr      = m_axi_awaddr;
                check_attrs(m_axi_awprot, m_axi_wstrb);
            end
        end

        // W channel
        m_axi_wready = 1'b0;
        if (m_axi_wvalid && !got_w) begin
            if (w_wait > 0) begin
                w_wait--;
            end else begin
                m_axi_wready = 1'b1;
                got_w        = 1'b1;
                cur.data     = m_axi_wdata;
            end
        end
    end

    // ----------------------------------------
    // Compare process
    // ----------------------------------------
    always @(posedge M_AXI_ACLK) begin : compare
        wr_cmd_t want;
        while (checked < wr_log.size()) begin
            if (!ref_write(checked, want)) begin
                abort_run($sformatf("write %0d arrived with no accepted byte left to send",
                                    checked));
            end else begin
                check_write(wr_log[checked], want, checked);
            end
            checked++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 10);
        abort_run($sformatf("timeout: only %0d of %0d accepted bytes were written",
                            okay_tx, accepted.size()));
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int i;
        M_AXI_ARESETN = 1'b0;
        xmit_data     = '0;
        xmit_wren     = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bvalid  = 1'b0;
        m_axi_bresp   = okay;
        stim_seed     = 32'h4af5_4585;
        slave_seed    = lcg_step(32'h4af5_4585);
        hold_aw       = 1'b0;
        got_aw        = 1'b0;
        got_w         = 1'b0;
        retry_run     = 0;
        okay_tx       = 0;
        checked       = 0;
        dropped       = 0;
        cur           = '0;
        reload_delays();

        repeat (4) @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b1;
        check_full(xmit_full_n, 1'b1, "xmit_full_n after reset");

        // Bytes at random gaps, drained while pushing
        for (i = 0; i < RAND_BYTES; i++) begin
            stim_seed = lcg_step(stim_seed);
            repeat (stim_seed[19:16] % 12) @(negedge M_AXI_ACLK);
            stim_seed = lcg_step(stim_seed);
            push_byte(stim_seed[23:16]);
        end
        wait_drained();

        // Stall AW and overfill the FIFO
        @(posedge M_AXI_ACLK);
        hold_aw = 1'b1;
        @(negedge M_AXI_ACLK);
        dropped = 0;
        for (i = 0; i < HOLD_PUSHES; i++) begin
            stim_seed = lcg_step(stim_seed);
            push_byte(stim_seed[23:16]);
        end
        check_full(xmit_full_n, 1'b0, "xmit_full_n with awready held low");
        if (dropped == 0) begin
            abort_run("no byte was refused although the FIFO should have filled up");
        end
        repeat (HOLD_CYCLES) @(negedge M_AXI_ACLK);
        check_full(xmit_full_n, 1'b0, "xmit_full_n after the stall");

        // Release and let everything drain
        @(posedge M_AXI_ACLK);
        hold_aw = 1'b0;
        @(negedge M_AXI_ACLK);
        wait_drained();
        check_full(xmit_full_n, 1'b1, "xmit_full_n after draining");

        // Quiet time so a stray extra write would still be caught
        repeat (20) @(negedge M_AXI_ACLK);
        // Bus must be at rest with every logged write compared
        if (!m_axi_awvalid && !m_axi_wvalid && !m_axi_bready &&
            checked == wr_log.size() && okay_tx == accepted.size()) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("a write was still in flight or left unchecked at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: list.f
common/uart_bridge_pkg.sv
hw/xmit_fifo.sv
hw/uart_tx_sequencer.sv
axi_write/axi_write_master.sv
hw/fifo_to_uart_tx.sv
test/fifo_to_uart_tx_sva.sv
test/tb_fifo_to_uart_tx.sv

// File: Bender.yml
package:
  name: fifo_to_uart_tx

sources:
  # Shared package
  - files:
      - common/uart_bridge_pkg.sv
  # Design
  - files:
      - hw/xmit_fifo.sv
      - hw/uart_tx_sequencer.sv
      - axi_write/axi_write_master.sv
      - hw/fifo_to_uart_tx.sv
  # Testbench
  - target: test
    files:
      - test/fifo_to_uart_tx_sva.sv
      - test/tb_fifo_to_uart_tx.sv
